/* Bender.yml */
package:
  name: color_tracker

sources:
  - tracker_pkg.sv
  - color_convert.sv
  - mask_threshold.sv
  - box_tracker.sv
  - frame_control.sv
  - box_overlay.sv
  - color_tracker.sv
  - target: test
    files:
      - color_tracker_assert.sv
      - tb_color_tracker.sv

/* box_overlay.sv */
module box_overlay (
  input  tracker_pkg::video_pixel_t stage_in,
  input  tracker_pkg::rgb888_t      rgb,
  input  logic [7:0]                channel,
  input  logic [7:0]                cr,
  input  logic                      mask,
  input  tracker_pkg::display_e     display,
  input  tracker_pkg::box_t         box,
  output tracker_pkg::video_out_t   pixel_out
);
  import tracker_pkg::*;

  rgb888_t background;
  logic    on_side;   // left or right edge
  logic    on_top;    // top or bottom edge
  logic    on_outline;

  always_comb begin
    case (display)
      CAMERA:    background = rgb;
      CHANNEL:   background = '{channel, channel, channel};
      MASK:      background = mask ? '{OUTLINE_LEVEL, OUTLINE_LEVEL, OUTLINE_LEVEL} : '0;
      MASK_OVER: background = mask ? MASK_TINT : '{cr, cr, cr};
      default:   background = rgb;
    endcase
  end

  assign on_side = ((stage_in.hcount == box.x_min) || (stage_in.hcount == box.x_max)) &&
                   (stage_in.vcount >= box.y_min) && (stage_in.vcount <= box.y_max);
  assign on_top  = ((stage_in.vcount == box.y_min) || (stage_in.vcount == box.y_max)) &&
                   (stage_in.hcount >= box.x_min) && (stage_in.hcount <= box.x_max);
  assign on_outline = box.valid && (on_side || on_top);

  assign pixel_out = '{valid:  stage_in.valid,
                       hcount: stage_in.hcount,
                       vcount: stage_in.vcount,
                       rgb888: on_outline ? '{OUTLINE_LEVEL, OUTLINE_LEVEL, OUTLINE_LEVEL}
                                          : background};

endmodule

/* box_tracker.sv */
module box_tracker (
  input  logic                            clk_pixel,
  input  logic                            sys_rst,
  input  logic [tracker_pkg::H_BITS-1:0]  hcount,
  input  logic [tracker_pkg::V_BITS-1:0]  vcount,
  input  logic                            mask,
  input  logic                            track,   // strobe pixel inside a frame
  input  logic                            restart, // first pixel of a new frame
  output tracker_pkg::box_t               running
);
  import tracker_pkg::*;

  box_t pixel_box; // box holding this pixel alone

  assign pixel_box = '{valid: 1'b1,
                       x_min: hcount,
                       x_max: hcount,
                       y_min: vcount,
                       y_max: vcount};

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      running <= '0;
    end else if (restart) begin
      running <= mask ? pixel_box : '0; // frame starts empty unless this pixel is masked
    end else if (track && mask) begin
      if (!running.valid) begin
        running <= pixel_box; // first masked pixel of the frame
      end else begin
        if (hcount < running.x_min) running.x_min <= hcount;
        if (hcount > running.x_max) running.x_max <= hcount;
        if (vcount < running.y_min) running.y_min <= vcount;
        if (vcount > running.y_max) running.y_max <= vcount;
      end
    end
  end

endmodule

/* color_convert.sv */
module color_convert (
  input  logic                      clk_pixel,
  input  logic                      sys_rst,
  input  tracker_pkg::video_pixel_t pixel_in,
  output tracker_pkg::video_pixel_t stage_out, // strobe fields only, rgb565 zeroed
  output tracker_pkg::rgb888_t      rgb,
  output tracker_pkg::ycrcb_t       ycc
);
  import tracker_pkg::*;

  rgb888_t expanded; // zero padded 888 of the incoming pixel

  // stage 1
  logic              s1_valid;
  logic              s1_new_frame;
  logic [H_BITS-1:0] s1_hcount;
  logic [V_BITS-1:0] s1_vcount;
  rgb888_t           s1_rgb;
  logic [15:0]       y_r, y_g, y_b;    // luma products
  logic [15:0]       cb_r, cb_g, cb_b; // blue chroma products
  logic [15:0]       cr_r, cr_g, cr_b; // red chroma products

  // stage 2 arithmetic
  logic [17:0]        y_sum;
  logic signed [17:0] cb_sum;
  logic signed [17:0] cr_sum;
  logic signed [17:0] y_val;
  logic signed [17:0] cb_val;
  logic signed [17:0] cr_val;

  logic              s2_valid;
  logic              s2_new_frame;
  logic [H_BITS-1:0] s2_hcount;
  logic [V_BITS-1:0] s2_vcount;

  function automatic logic [7:0] clamp_byte(input logic signed [17:0] value);
    if (value < 18'sd0) begin
      return 8'd0;
    end else if (value > 18'sd255) begin
      return 8'd255;
    end else begin
      return value[7:0];
    end
  endfunction

  assign expanded = '{red:   {pixel_in.rgb565[15:11], 3'b000},
                      green: {pixel_in.rgb565[10:5], 2'b00},
                      blue:  {pixel_in.rgb565[4:0], 3'b000}};

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= pixel_in.valid;
      s2_valid <= s1_valid;
    end
  end

  // stage 1: expand and multiply
  always_ff @(posedge clk_pixel) begin
    s1_new_frame <= pixel_in.new_frame;
    s1_hcount    <= pixel_in.hcount;
    s1_vcount    <= pixel_in.vcount;
    s1_rgb       <= expanded;
    y_r  <= 16'd77 * expanded.red;
    y_g  <= 16'd150 * expanded.green;
    y_b  <= 16'd29 * expanded.blue;
    cb_r <= 16'd43 * expanded.red;   // subtracted
    cb_g <= 16'd85 * expanded.green; // subtracted
    cb_b <= 16'd128 * expanded.blue;
    cr_r <= 16'd128 * expanded.red;
    cr_g <= 16'd107 * expanded.green; // subtracted
    cr_b <= 16'd21 * expanded.blue;   // subtracted
  end

  assign y_sum  = y_r + y_g + y_b; // never negative
  assign cb_sum = $signed({2'b00, cb_b}) - $signed({2'b00, cb_r}) - $signed({2'b00, cb_g});
  assign cr_sum = $signed({2'b00, cr_r}) - $signed({2'b00, cr_g}) - $signed({2'b00, cr_b});

  assign y_val  = $signed(y_sum >> 8);
  assign cb_val = (cb_sum >>> 8) + 18'sd128; // chroma centered on 128
  assign cr_val = (cr_sum >>> 8) + 18'sd128;

  // stage 2: sum, shift, offset, clamp
  always_ff @(posedge clk_pixel) begin
    s2_new_frame <= s1_new_frame;
    s2_hcount    <= s1_hcount;
    s2_vcount    <= s1_vcount;
    rgb          <= s1_rgb;
    ycc          <= '{y: clamp_byte(y_val), cr: clamp_byte(cr_val), cb: clamp_byte(cb_val)};
  end

  assign stage_out = '{valid:     s2_valid,
                       new_frame: s2_new_frame,
                       hcount:    s2_hcount,
                       vcount:    s2_vcount,
                       rgb565:    16'h0000};

endmodule

/* color_tracker.f */
tracker_pkg.sv
color_convert.sv
mask_threshold.sv
box_tracker.sv
frame_control.sv
box_overlay.sv
color_tracker.sv
color_tracker_assert.sv
tb_color_tracker.sv

/* color_tracker.sv */
module color_tracker (
  input  logic                      clk_pixel,
  input  logic                      sys_rst,
  input  tracker_pkg::video_pixel_t pixel_in,   // single cycle strobe, no back-pressure
  input  tracker_pkg::tracker_cfg_t cfg,        // quasi-static
  output tracker_pkg::video_out_t   pixel_out,
  output tracker_pkg::box_t         box,
  output logic                      box_update
);
  import tracker_pkg::*;

  // stage 2, after conversion
  video_pixel_t s2_pixel;
  rgb888_t      s2_rgb;
  ycrcb_t       s2_ycc;

  // stage 3, after channel select and threshold
  video_pixel_t s3_pixel;
  rgb888_t      s3_rgb;
  logic [7:0]   s3_channel;
  logic [7:0]   s3_cr;
  logic         s3_mask;

  logic track;
  logic restart;
  box_t running; // box of the frame in progress

  color_convert color_convert_inst (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .pixel_in  (pixel_in),
    .stage_out (s2_pixel),
    .rgb       (s2_rgb),
    .ycc       (s2_ycc)
  );

  mask_threshold mask_threshold_inst (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .stage_in  (s2_pixel),
    .rgb       (s2_rgb),
    .ycc       (s2_ycc),
    .cfg       (cfg),
    .stage_out (s3_pixel),
    .rgb_out   (s3_rgb),
    .channel   (s3_channel),
    .cr        (s3_cr),
    .mask      (s3_mask)
  );

  box_tracker box_tracker_inst (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .hcount    (s3_pixel.hcount),
    .vcount    (s3_pixel.vcount),
    .mask      (s3_mask),
    .track     (track),
    .restart   (restart),
    .running   (running)
  );

  frame_control frame_control_inst (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .strobe     (s3_pixel.valid),
    .new_frame  (s3_pixel.new_frame),
    .running    (running),
    .track      (track),
    .restart    (restart),
    .box        (box),
    .box_update (box_update)
  );

  box_overlay box_overlay_inst (
    .stage_in  (s3_pixel),
    .rgb       (s3_rgb),
    .channel   (s3_channel),
    .cr        (s3_cr),
    .mask      (s3_mask),
    .display   (cfg.display),
    .box       (box),         // published box, ahead of the pixel
    .pixel_out (pixel_out)
  );

endmodule

/* color_tracker_assert.sv */
module color_tracker_assert (
  input logic                      clk_pixel,
  input logic                      sys_rst,
  input tracker_pkg::video_pixel_t pixel_in,
  input tracker_pkg::video_out_t   pixel_out,
  input tracker_pkg::box_t         box,
  input logic                      box_update
);
  import tracker_pkg::*;

  // publish is a single cycle pulse, frames are never one pixel long
  single_update: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box_update |=> !box_update)
    else $error("box_update high on two consecutive cycles");

  // fixed latency, no stalls anywhere in the pipe
  pipe_latency: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    pixel_out.valid == $past(pixel_in.valid, PIPE_LATENCY))
    else $error("pixel_out.valid does not follow pixel_in.valid by the pipeline latency");

  box_order: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box.valid |-> (box.x_min <= box.x_max))
    else $error("valid box with x_min above x_max");

endmodule

/* frame_control.sv */
module frame_control (
  input  logic              clk_pixel,
  input  logic              sys_rst,
  input  logic              strobe,    // stage 3 pixel valid
  input  logic              new_frame,
  input  tracker_pkg::box_t running,
  output logic              track,
  output logic              restart,
  output tracker_pkg::box_t box,       // published box, held between frames
  output logic              box_update
);
  import tracker_pkg::*;

  frame_state_e state;

  // no box is tracked before the first frame start
  assign track   = strobe && (state == TRACKING);
  assign restart = strobe && new_frame;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state      <= WAIT_FIRST;
      box        <= '0;
      box_update <= 1'b0;
    end else begin
      box_update <= 1'b0; // single cycle pulse
      if (strobe && new_frame) begin
        state <= TRACKING;
        if (state == TRACKING) begin
          box        <= running; // last frame's box, valid low if nothing was masked
          box_update <= 1'b1;
        end
      end
    end
  end

endmodule

/* mask_threshold.sv */
module mask_threshold (
  input  logic                      clk_pixel,
  input  logic                      sys_rst,
  input  tracker_pkg::video_pixel_t stage_in,
  input  tracker_pkg::rgb888_t      rgb,
  input  tracker_pkg::ycrcb_t       ycc,
  input  tracker_pkg::tracker_cfg_t cfg,
  output tracker_pkg::video_pixel_t stage_out,
  output tracker_pkg::rgb888_t      rgb_out,
  output logic [7:0]                channel, // selected channel value
  output logic [7:0]                cr,      // kept for the mask overlay mode
  output logic                      mask
);
  import tracker_pkg::*;

  logic [7:0]        selected;
  logic              in_window;
  logic              valid_q;
  logic              new_frame_q;
  logic [H_BITS-1:0] hcount_q;
  logic [V_BITS-1:0] vcount_q;

  always_comb begin
    case (cfg.channel)
      GREEN:       selected = rgb.green;
      RED:         selected = rgb.red;
      BLUE:        selected = rgb.blue;
      LUMA:        selected = ycc.y;
      CHROMA_RED:  selected = ycc.cr;
      CHROMA_BLUE: selected = ycc.cb;
      default:     selected = 8'd0; // codes 3 and 7
    endcase
  end

  // both bounds inclusive, equal bounds pass exactly one level
  assign in_window = (selected >= cfg.lower) && (selected <= cfg.upper);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= stage_in.valid;
    end
  end

  always_ff @(posedge clk_pixel) begin
    new_frame_q <= stage_in.new_frame;
    hcount_q    <= stage_in.hcount;
    vcount_q    <= stage_in.vcount;
    rgb_out     <= rgb;
    channel     <= selected;
    cr          <= ycc.cr;
    mask        <= in_window;
  end

  assign stage_out = '{valid:     valid_q,
                       new_frame: new_frame_q,
                       hcount:    hcount_q,
                       vcount:    vcount_q,
                       rgb565:    16'h0000};

endmodule

/* tb_color_tracker.sv */
module tb_color_tracker;
  import tracker_pkg::*;

  localparam int FRAME_H     = 16;
  localparam int FRAME_V     = 12;
  localparam int RANDOM_FILL = 0;
  localparam int BLACK_FILL  = 1;
  localparam int REGION_FILL = 2; // red rectangle on black
  localparam int REG_X0      = 3;
  localparam int REG_X1      = 9;
  localparam int REG_Y0      = 2;
  localparam int REG_Y1      = 7;
  localparam int DRAIN_LIMIT = 100; // cycles

  logic         clk_pixel;
  logic         sys_rst;
  video_pixel_t pixel_in;
  tracker_cfg_t cfg;
  video_out_t   pixel_out;
  box_t         box;
  logic         box_update;

  // expected outputs with the cycle they are due in
  video_out_t  pix_q[$];
  int unsigned pix_cyc_q[$];
  box_t        box_q[$];
  int unsigned box_cyc_q[$];

  // reference state of the frame tracker
  logic model_tracking;
  box_t model_running;
  box_t model_pub;

  int unsigned cycle = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int test_errors_base = 0;
  int box_update_count = 0;
  int outline_count = 0; // white pixels seen on pixel_out
  logic [2:0] codes [6] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6}; // defined channel codes

  color_tracker color_tracker_inst (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .pixel_in   (pixel_in),
    .cfg        (cfg),
    .pixel_out  (pixel_out),
    .box        (box),
    .box_update (box_update)
  );

  bind color_tracker color_tracker_assert color_tracker_assert_inst (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .pixel_in   (pixel_in),
    .pixel_out  (pixel_out),
    .box        (box),
    .box_update (box_update)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #4 clk_pixel = ~clk_pixel;
  end

  always @(posedge clk_pixel) cycle <= cycle + 1; // timestamps for latency checks

  task automatic report_error(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("error at time %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic rgb888_t expand_rgb565(input logic [15:0] c);
    return '{red: {c[15:11], 3'b000}, green: {c[10:5], 2'b00}, blue: {c[4:0], 3'b000}};
  endfunction

  function automatic logic [7:0] clamp_to_byte(input int value);
    if (value < 0) return 8'd0;
    if (value > 255) return 8'd255;
    return value[7:0];
  endfunction

  function automatic ycrcb_t convert_ycrcb(input rgb888_t c);
    int r;
    int g;
    int b;
    ycrcb_t res;
    r = c.red;
    g = c.green;
    b = c.blue;
    res.y  = clamp_to_byte((77 * r + 150 * g + 29 * b) >>> 8);
    res.cb = clamp_to_byte(128 + ((-43 * r - 85 * g + 128 * b) >>> 8)); // arithmetic shift
    res.cr = clamp_to_byte(128 + ((128 * r - 107 * g - 21 * b) >>> 8));
    return res;
  endfunction

  function automatic logic [7:0] select_channel(input rgb888_t c, input ycrcb_t ycc,
                                                input logic [2:0] code);
    case (code)
      3'd0:    return c.green;
      3'd1:    return c.red;
      3'd2:    return c.blue;
      3'd4:    return ycc.y;
      3'd5:    return ycc.cr;
      3'd6:    return ycc.cb;
      default: return 8'd0; // 3 and 7
    endcase
  endfunction

  function automatic logic window_mask(input logic [15:0] color, input tracker_cfg_t c);
    rgb888_t    rgb;
    logic [7:0] ch;
    rgb = expand_rgb565(color);
    ch  = select_channel(rgb, convert_ycrcb(rgb), c.channel);
    return (ch >= c.lower) && (ch <= c.upper); // inclusive
  endfunction

  function automatic logic on_outline(input int h, input int v, input box_t b);
    logic side;
    logic edge_tb;
    side    = (h == b.x_min || h == b.x_max) && v >= b.y_min && v <= b.y_max;
    edge_tb = (v == b.y_min || v == b.y_max) && h >= b.x_min && h <= b.x_max;
    return b.valid && (side || edge_tb);
  endfunction

  function automatic box_t grow_box(input box_t b, input int h, input int v);
    box_t res;
    if (!b.valid) return '{valid: 1'b1, x_min: h, x_max: h, y_min: v, y_max: v};
    res = b;
    if (h < b.x_min) res.x_min = h;
    if (h > b.x_max) res.x_max = h;
    if (v < b.y_min) res.y_min = v;
    if (v > b.y_max) res.y_max = v;
    return res;
  endfunction

  // expected output pixel for an input pixel, config and the box shown at stage 3
  function automatic video_out_t expected_pixel(input video_pixel_t p, input tracker_cfg_t c,
                                                input box_t b);
    rgb888_t    rgb;
    ycrcb_t     ycc;
    logic [7:0] ch;
    logic       hit;
    video_out_t res;
    rgb = expand_rgb565(p.rgb565);
    ycc = convert_ycrcb(rgb);
    ch  = select_channel(rgb, ycc, c.channel);
    hit = window_mask(p.rgb565, c);
    res.valid  = 1'b1;
    res.hcount = p.hcount;
    res.vcount = p.vcount;
    case (c.display)
      CAMERA:  res.rgb888 = rgb;
      CHANNEL: res.rgb888 = {ch, ch, ch};
      MASK:    res.rgb888 = hit ? 24'hFFFFFF : 24'h000000;
      default: res.rgb888 = hit ? 24'hFF00FF : {ycc.cr, ycc.cr, ycc.cr}; // magenta tint
    endcase
    if (on_outline(p.hcount, p.vcount, b)) res.rgb888 = 24'hFFFFFF;
    return res;
  endfunction

  function automatic logic [15:0] frame_color(input int kind, input int h, input int v);
    logic [15:0] c;
    c = $urandom();
    if (kind == BLACK_FILL) return 16'h0000;
    if (kind == REGION_FILL) begin
      return (h >= REG_X0 && h <= REG_X1 && v >= REG_Y0 && v <= REG_Y1) ? 16'hF800 : 16'h0000;
    end
    return c;
  endfunction

  task automatic set_config(input logic [2:0] code, input logic [7:0] lo,
                            input logic [7:0] hi, input display_e d);
    cfg = '{channel: channel_e'(code), lower: lo, upper: hi, display: d};
  endtask

  // called on a falling edge, returns on a falling edge after a random gap
  task automatic send_pixel(input logic nf, input int h, input int v, input logic [15:0] color);
    video_pixel_t p;
    logic         hit;
    p = '{valid: 1'b1, new_frame: nf, hcount: h, vcount: v, rgb565: color};
    pixel_in = p;
    pix_q.push_back(expected_pixel(p, cfg, model_pub)); // box before this frame's publish
    pix_cyc_q.push_back(cycle + PIPE_LATENCY);
    hit = window_mask(color, cfg);
    if (nf) begin
      if (model_tracking) begin
        model_pub = model_running;
        box_q.push_back(model_running);
        box_cyc_q.push_back(cycle + PIPE_LATENCY + 1);
      end
      model_tracking = 1'b1;
      model_running  = hit ? grow_box('0, h, v) : '0; // frame restarts on this pixel
    end else if (model_tracking && hit) begin
      model_running = grow_box(model_running, h, v);
    end
    @(negedge clk_pixel);
    pixel_in.valid = 1'b0;
    repeat ($urandom_range(3)) @(negedge clk_pixel);
  endtask

  task automatic drain(input string what);
    int n;
    for (n = 0; n < DRAIN_LIMIT && (pix_q.size() != 0 || box_q.size() != 0); n++) begin
      @(negedge clk_pixel);
    end
    if (pix_q.size() != 0 || box_q.size() != 0) begin
      report_problem($sformatf("timeout, outputs of %s still pending after %0d cycles",
                               what, DRAIN_LIMIT));
      pix_q.delete();
      pix_cyc_q.delete();
      box_q.delete();
      box_cyc_q.delete();
    end
  endtask

  task automatic send_frame(input int kind);
    int h;
    int v;
    for (v = 0; v < FRAME_V; v++) begin
      for (h = 0; h < FRAME_H; h++) begin
        send_pixel(h == 0 && v == 0, h, v, frame_color(kind, h, v));
      end
    end
    drain("frame");
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors_base) $display("test %0d %s: ok", tests_run, name);
    else $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors_base);
    test_errors_base = errors;
  endtask

  // output checker, sampled at falling edges where the DUT outputs are settled
  initial begin : compare_outputs
    video_out_t  want_pix;
    box_t        want_box;
    int unsigned want_cyc;
    forever begin
      @(negedge clk_pixel);
      if (pixel_out.valid) begin
        if (pixel_out.rgb888 == {OUTLINE_LEVEL, OUTLINE_LEVEL, OUTLINE_LEVEL}) begin
          outline_count++;
        end
        assert (pix_q.size() != 0) else report_problem("pixel_out strobe with no pixel expected");
        if (pix_q.size() != 0) begin
          want_pix = pix_q.pop_front();
          want_cyc = pix_cyc_q.pop_front();
          checks++;
          assert (cycle == want_cyc)
            else report_problem($sformatf("pixel came at cycle %0d, not %0d", cycle, want_cyc));
          assert (pixel_out == want_pix)
            else report_error($sformatf("pixel_out %h, expected %h", pixel_out, want_pix));
        end
      end else if (pix_cyc_q.size() != 0 && pix_cyc_q[0] <= cycle) begin
        report_problem($sformatf("pixel due at cycle %0d never appeared", pix_cyc_q[0]));
        void'(pix_q.pop_front());
        void'(pix_cyc_q.pop_front());
      end
      if (box_update) begin
        box_update_count++;
        assert (box_q.size() != 0) else report_problem("box_update with no publish expected");
        if (box_q.size() != 0) begin
          want_box = box_q.pop_front();
          want_cyc = box_cyc_q.pop_front();
          checks++;
          assert (cycle == want_cyc)
            else report_problem($sformatf("box_update at cycle %0d, not %0d", cycle, want_cyc));
          assert (box == want_box)
            else report_error($sformatf("box %h, expected %h", box, want_box));
        end
      end else if (box_cyc_q.size() != 0 && box_cyc_q[0] <= cycle) begin
        report_problem($sformatf("box_update due at cycle %0d never came", box_cyc_q[0]));
        void'(box_q.pop_front());
        void'(box_cyc_q.pop_front());
      end
    end
  end

  initial begin : run_tests
    int         i;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] t;
    logic [2:0] code;
    box_t       region_box;
    void'($urandom(32'h44398fe1));
    sys_rst        = 1'b1;
    pixel_in       = '0;
    model_tracking = 1'b0;
    model_running  = '0;
    model_pub      = '0;
    region_box     = '{valid: 1'b1, x_min: REG_X0, x_max: REG_X1, y_min: REG_Y0, y_max: REG_Y1};
    set_config(3'd3, 8'd1, 8'd255, CAMERA); // zero channel outside window, nothing masked
    repeat (8) @(posedge clk_pixel);
    @(negedge clk_pixel);
    sys_rst = 1'b0;

    checks++;
    assert (!pixel_out.valid && !box_update && !box.valid)
      else report_error("outputs not cleared after reset");
    send_frame(RANDOM_FILL); // first frame ends nothing
    checks++;
    assert (box_update_count == 0 && !box.valid) else report_error("first frame was published");
    end_test("reset and first frame");

    send_frame(RANDOM_FILL);
    end_test("camera mode");

    for (i = 0; i < 8; i++) begin
      set_config(i[2:0], 8'd1, 8'd0, CHANNEL); // empty window keeps boxes empty
      send_frame(RANDOM_FILL);
    end
    end_test("channel select");

    for (i = 0; i < 6; i++) begin
      a    = $urandom();
      b    = $urandom();
      code = codes[$urandom_range(5)];
      if (a > b) begin
        t = a;
        a = b;
        b = t;
      end
      if (i >= 4) begin
        a      = $urandom();
        a[2:0] = 3'b000; // a level red can take
        b      = a;
        code   = 3'd1;
      end
      set_config(code, a, b, (i % 2 == 0) ? MASK : MASK_OVER);
      send_frame(RANDOM_FILL);
    end
    end_test("mask windows");

    set_config(3'd1, 8'h80, 8'hFF, CAMERA); // red threshold
    send_frame(REGION_FILL);
    send_frame(BLACK_FILL);
    checks++;
    assert (box == region_box) else report_error($sformatf("published box %h", box));
    send_frame(BLACK_FILL);
    checks++;
    assert (!box.valid) else report_error("empty frame published a valid box");
    end_test("box publish");

    set_config(3'd1, 8'h80, 8'hFF, MASK);
    send_frame(REGION_FILL);
    set_config(3'd1, 8'h80, 8'hFF, MASK_OVER);
    outline_count = 0;
    send_frame(RANDOM_FILL); // white here only on the outline, cr never reaches FF
    checks++;
    assert (outline_count == 2 * (REG_X1 - REG_X0 + 1) + 2 * (REG_Y1 - REG_Y0 - 1))
      else report_error($sformatf("%0d white pixels in the outline frame", outline_count));
    end_test("box outline");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tracker_pkg.sv */
package tracker_pkg;

  localparam int H_BITS       = 11; // horizontal coordinate width
  localparam int V_BITS       = 10; // vertical coordinate width
  localparam int PIPE_LATENCY = 3;  // pixel_in strobe to pixel_out strobe, in cycles

  localparam logic [7:0] OUTLINE_LEVEL = 8'hFF; // white

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // magenta, painted over masked pixels
  localparam rgb888_t MASK_TINT = '{red: 8'hFF, green: 8'h00, blue: 8'hFF};

  typedef struct packed {
    logic              valid;     // one pixel this cycle
    logic              new_frame; // first pixel of a frame
    logic [H_BITS-1:0] hcount;
    logic [V_BITS-1:0] vcount;
    logic [15:0]       rgb565;
  } video_pixel_t;

  typedef struct packed {
    logic [7:0] y;
    logic [7:0] cr;
    logic [7:0] cb;
  } ycrcb_t;

  typedef struct packed {
    logic              valid;
    logic [H_BITS-1:0] hcount;
    logic [V_BITS-1:0] vcount;
    rgb888_t           rgb888;
  } video_out_t;

  typedef struct packed {
    logic              valid; // at least one masked pixel inside
    logic [H_BITS-1:0] x_min;
    logic [H_BITS-1:0] x_max;
    logic [V_BITS-1:0] y_min;
    logic [V_BITS-1:0] y_max;
  } box_t;

  // codes 3 and 7 are left out and select zero
  typedef enum logic [2:0] {
    GREEN       = 3'd0,
    RED         = 3'd1,
    BLUE        = 3'd2,
    LUMA        = 3'd4,
    CHROMA_RED  = 3'd5,
    CHROMA_BLUE = 3'd6
  } channel_e;

  typedef enum logic [1:0] {
    CAMERA,    // camera pixel
    CHANNEL,   // selected channel as gray
    MASK,      // white where masked, black elsewhere
    MASK_OVER  // cr as gray, magenta where masked
  } display_e;

  typedef struct packed {
    channel_e   channel;
    logic [7:0] lower;   // inclusive
    logic [7:0] upper;   // inclusive
    display_e   display;
  } tracker_cfg_t;

  typedef enum logic {
    WAIT_FIRST,
    TRACKING
  } frame_state_e;

endpackage
